// ==== include/xge_defines.svh ====
/* XGE interface constants
   Host register map, config reset value and XGMII control characters */
`ifndef XGE_DEFINES_SVH
`define XGE_DEFINES_SVH

`default_nettype none

// ----------------------------------------
// Host register map (10-bit addresses)
`define XGE_ADDR_CFG          10'h000
`define XGE_ADDR_TX_CNT       10'h004
`define XGE_ADDR_RX_GOOD_CNT  10'h008
`define XGE_ADDR_RX_BAD_CNT   10'h00C

`define XGE_CFG_RESET         2'b11    // Rx enable, tx enable

// ----------------------------------------
// XGMII control and framing characters
`define XGMII_IDLE            8'h07
`define XGMII_START           8'hFB
`define XGMII_TERM            8'hFD
`define XGMII_ERROR           8'hFE
`define XGMII_PREAMBLE        8'h55
`define XGMII_SFD             8'hD5

`default_nettype wire

`endif

// ==== rtl/xge_mac_pkg.sv ====
/* MAC-side types for the XGMII transmit and receive paths */
`include "xge_defines.svh"

`default_nettype none

package xge_mac_pkg;

    // XGMII characters seen on control lanes
    typedef enum logic [7:0] {
        CH_IDLE     = `XGMII_IDLE,
        CH_START    = `XGMII_START,
        CH_TERM     = `XGMII_TERM,
        CH_ERROR    = `XGMII_ERROR,
        CH_PREAMBLE = `XGMII_PREAMBLE,
        CH_SFD      = `XGMII_SFD
    } xgmii_char_t;

    typedef enum logic [1:0] {
        TX_IDLE,    // Waiting for tx_start
        TX_ACK,     // Ack and start word out
        TX_DATA,    // Client words streaming
        TX_GAP      // Forced idle word
    } tx_state_t;

    typedef enum logic {
        RX_IDLE,
        RX_FRAME
    } rx_state_t;

endpackage

`default_nettype wire

// ==== rtl/xge_host_pkg.sv ====
/* Host management types, opcodes and decoded operations */
`default_nettype none

package xge_host_pkg;

    typedef enum logic [1:0] {
        HOST_NOP        = 2'b00,
        HOST_WRITE      = 2'b01,
        HOST_READ       = 2'b10,
        HOST_READ_CLEAR = 2'b11
    } host_opcode_t;

    // One operation per request, clear flag travels beside it
    typedef enum logic [2:0] {
        OP_NONE,
        OP_WR_CFG,
        OP_RD_CFG,
        OP_RD_TX,
        OP_RD_RX_GOOD,
        OP_RD_RX_BAD,
        OP_RD_UNMAPPED
    } host_op_t;

endpackage

`default_nettype wire

// ==== rtl/mac_tx.sv ====
/* Transmit MAC
   Frames client words onto XGMII with start, terminate and error characters */
`default_nettype none

module mac_tx import xge_mac_pkg::*; (
    input  logic        clk156_25,
    input  logic        arst_n,
    input  logic        tx_enable,
    input  logic        tx_start,
    input  logic        tx_underrun,
    input  logic [63:0] tx_data,
    input  logic [7:0]  tx_data_valid,
    output logic        tx_ack,
    output logic [63:0] xgmii_txd,
    output logic [7:0]  xgmii_txc,
    output logic        tx_frame_done
);

    tx_state_t   state;
    logic [63:0] word_d;        // Lane image of the client word
    logic [7:0]  word_c;
    logic [7:0]  prev_valid;    // Valid bit of the lane below
    logic        last_word;

    assign prev_valid = {tx_data_valid[6:0], 1'b1};
    assign last_word  = (tx_data_valid != 8'hFF);

    // ----------------------------------------
    // Lane mapping of the current client word
    always_comb begin
        word_d = '0;
        word_c = '0;
        for (int i = 0; i < 8; i++) begin
            if (tx_underrun) begin
                word_d[8*i +: 8] = CH_ERROR;    // Whole word poisoned
                word_c[i]        = 1'b1;
            end else if (tx_data_valid[i]) begin
                word_d[8*i +: 8] = tx_data[8*i +: 8];
            end else if (prev_valid[i]) begin
                word_d[8*i +: 8] = CH_TERM;     // First empty lane
                word_c[i]        = 1'b1;
            end else begin
                word_d[8*i +: 8] = CH_IDLE;
                word_c[i]        = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Framing FSM, all outputs registered
    always_ff @(posedge clk156_25 or negedge arst_n) begin
        if (!arst_n) begin
            state         <= TX_IDLE;
            tx_ack        <= 1'b0;
            tx_frame_done <= 1'b0;
            xgmii_txd     <= {8{CH_IDLE}};
            xgmii_txc     <= 8'hFF;
        end else begin
            tx_ack        <= 1'b0;
            tx_frame_done <= 1'b0;
            xgmii_txd     <= {8{CH_IDLE}};  // Idle unless a word is due
            xgmii_txc     <= 8'hFF;
            case (state)
                TX_IDLE: begin
                    if (tx_start && tx_enable) begin
                        state     <= TX_ACK;
                        tx_ack    <= 1'b1;
                        xgmii_txd <= {CH_SFD, {6{CH_PREAMBLE}}, CH_START};
                        xgmii_txc <= 8'h01;     // Only lane 0 is control
                    end
                end
                TX_ACK: begin
                    state <= TX_DATA;   // Idle lead-in, client fetches word 0
                end
                TX_DATA: begin
                    xgmii_txd <= word_d;
                    xgmii_txc <= word_c;
                    if (tx_underrun || last_word) begin
                        state <= TX_GAP;
                    end
                    tx_frame_done <= !tx_underrun && last_word; // Terminate sent
                end
                TX_GAP: begin
                    state <= TX_IDLE;   // One idle word between frames
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mac_rx.sv ====
/* Receive MAC
   Deframes XGMII words into client words and flags good or bad frames */
`default_nettype none

module mac_rx import xge_mac_pkg::*; (
    input  logic        clk156_25,
    input  logic        arst_n,
    input  logic        rx_enable,
    input  logic [63:0] xgmii_rxd,
    input  logic [7:0]  xgmii_rxc,
    output logic [63:0] rx_data,
    output logic [7:0]  rx_data_valid,
    output logic        rx_good_frame,
    output logic        rx_bad_frame
);

    rx_state_t  state;
    logic [7:0] term_hit;       // Terminate per lane
    logic [7:0] err_hit;        // Error per lane
    logic [2:0] term_lane;      // Lowest terminate lane
    logic [7:0] term_mask;
    logic       sof;

    // ----------------------------------------
    // Control lane scan
    always_comb begin
        term_hit  = '0;
        err_hit   = '0;
        term_lane = 3'd0;
        for (int i = 0; i < 8; i++) begin
            term_hit[i] = xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == CH_TERM);
            err_hit[i]  = xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == CH_ERROR);
        end
        for (int i = 7; i >= 0; i--) begin
            if (term_hit[i]) begin
                term_lane = 3'(i);  // Lowest lane wins
            end
        end
    end

    assign term_mask = (8'd1 << term_lane) - 8'd1;     // k low bytes valid
    assign sof       = rx_enable && xgmii_rxc[0] && (xgmii_rxd[7:0] == CH_START);

    always_ff @(posedge clk156_25 or negedge arst_n) begin
        if (!arst_n) begin
            state         <= RX_IDLE;
            rx_data       <= '0;
            rx_data_valid <= '0;
            rx_good_frame <= 1'b0;
            rx_bad_frame  <= 1'b0;
        end else begin
            rx_data       <= xgmii_rxd;     // Payload registered with the judgment
            rx_data_valid <= '0;
            rx_good_frame <= 1'b0;
            rx_bad_frame  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (sof) begin
                        state <= RX_FRAME;  // Start word is dropped
                    end
                end
                RX_FRAME: begin
                    if (|err_hit) begin
                        rx_bad_frame <= 1'b1;   // Error beats terminate
                        state        <= RX_IDLE;
                    end else if (|term_hit) begin
                        rx_data_valid <= term_mask;
                        rx_good_frame <= 1'b1;
                        state         <= RX_IDLE;
                    end else begin
                        rx_data_valid <= ~xgmii_rxc;    // Idle filler gives 0
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_decode.sv ====
/* Host decode stage, registers a request and maps opcode and address */
`include "xge_defines.svh"

`default_nettype none

module host_decode import xge_host_pkg::*; (
    input  logic         clk156_25,
    input  logic         arst_n,
    input  logic         host_req,
    input  host_opcode_t host_opcode,
    input  logic [9:0]   host_addr,
    input  logic [31:0]  host_wr_data,
    output logic         dec_valid,
    output host_op_t     dec_op,
    output logic         dec_clear,
    output logic [31:0]  dec_wr_data
);

    host_op_t op_d;
    logic     clear_d;
    logic     is_counter;

    assign is_counter = host_addr inside {`XGE_ADDR_TX_CNT, `XGE_ADDR_RX_GOOD_CNT,
                                          `XGE_ADDR_RX_BAD_CNT};

    always_comb begin
        op_d = OP_NONE;
        case (host_opcode)
            HOST_NOP: begin
                op_d = OP_NONE;
            end
            HOST_WRITE: begin
                if (host_addr == `XGE_ADDR_CFG) begin
                    op_d = OP_WR_CFG;   // Other write targets dropped
                end
            end
            HOST_READ, HOST_READ_CLEAR: begin
                case (host_addr)
                    `XGE_ADDR_CFG:         op_d = OP_RD_CFG;
                    `XGE_ADDR_TX_CNT:      op_d = OP_RD_TX;
                    `XGE_ADDR_RX_GOOD_CNT: op_d = OP_RD_RX_GOOD;
                    `XGE_ADDR_RX_BAD_CNT:  op_d = OP_RD_RX_BAD;
                    default:               op_d = OP_RD_UNMAPPED;
                endcase
            end
            default: begin
                op_d = OP_NONE;
            end
        endcase
        if (!host_req) begin
            op_d = OP_NONE;
        end
    end

    assign clear_d = host_req && (host_opcode == HOST_READ_CLEAR) && is_counter;

    always_ff @(posedge clk156_25 or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid   <= 1'b0;
            dec_op      <= OP_NONE;
            dec_clear   <= 1'b0;
            dec_wr_data <= '0;
        end else begin
            dec_valid   <= host_req;
            dec_op      <= op_d;
            dec_clear   <= clear_d;
            dec_wr_data <= host_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_execute.sv ====
/* Host execute stage
   Config register and frame counters, updated by each decoded operation */
`include "xge_defines.svh"

`default_nettype none

module host_execute import xge_host_pkg::*; (
    input  logic        clk156_25,
    input  logic        arst_n,
    input  logic        dec_valid,
    input  host_op_t    dec_op,
    input  logic        dec_clear,
    input  logic [31:0] dec_wr_data,
    input  logic        tx_frame_done,
    input  logic        rx_good_frame,
    input  logic        rx_bad_frame,
    output logic        tx_enable,
    output logic        rx_enable,
    output logic        exe_valid,
    output host_op_t    exe_op,
    output logic [31:0] exe_value
);

    logic [1:0]  cfg;           // [0] tx enable, [1] rx enable
    logic [31:0] cnt [3];       // Tx, rx good, rx bad
    logic [2:0]  cnt_evt;
    logic [2:0]  cnt_clr;
    logic [31:0] sel_value;

    assign tx_enable = cfg[0];
    assign rx_enable = cfg[1];

    assign cnt_evt    = {rx_bad_frame, rx_good_frame, tx_frame_done};
    assign cnt_clr[0] = dec_valid && dec_clear && (dec_op == OP_RD_TX);
    assign cnt_clr[1] = dec_valid && dec_clear && (dec_op == OP_RD_RX_GOOD);
    assign cnt_clr[2] = dec_valid && dec_clear && (dec_op == OP_RD_RX_BAD);

    // Addressed value, taken before any clear or write lands
    always_comb begin
        case (dec_op)
            OP_RD_CFG:     sel_value = {30'd0, cfg};
            OP_RD_TX:      sel_value = cnt[0];
            OP_RD_RX_GOOD: sel_value = cnt[1];
            OP_RD_RX_BAD:  sel_value = cnt[2];
            default:       sel_value = '0;
        endcase
    end

    always_ff @(posedge clk156_25 or negedge arst_n) begin
        if (!arst_n) begin
            cfg       <= `XGE_CFG_RESET;
            exe_valid <= 1'b0;
            exe_op    <= OP_NONE;
            exe_value <= '0;
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            if (dec_valid && (dec_op == OP_WR_CFG)) begin
                cfg <= dec_wr_data[1:0];
            end
            for (int i = 0; i < 3; i++) begin
                if (cnt_clr[i]) begin
                    cnt[i] <= '0;               // Same-cycle event lost
                end else if (cnt_evt[i]) begin
                    cnt[i] <= cnt[i] + 32'd1;   // Wraps
                end
            end
            exe_valid <= dec_valid;
            exe_op    <= dec_op;
            exe_value <= sel_value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_result.sv ====
/* Host result stage, registers read data with the ready strobe */
`default_nettype none

module host_result import xge_host_pkg::*; (
    input  logic        clk156_25,
    input  logic        arst_n,
    input  logic        exe_valid,
    input  host_op_t    exe_op,
    input  logic [31:0] exe_value,
    output logic        host_rdy,
    output logic [31:0] host_rd_data
);

    logic is_read;

    // Mapped reads only, unmapped reads return zero
    assign is_read = exe_op inside {OP_RD_CFG, OP_RD_TX, OP_RD_RX_GOOD, OP_RD_RX_BAD};

    always_ff @(posedge clk156_25 or negedge arst_n) begin
        if (!arst_n) begin
            host_rdy     <= 1'b0;
            host_rd_data <= '0;
        end else begin
            host_rdy     <= exe_valid;
            host_rd_data <= (exe_valid && is_read) ? exe_value : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xge_intf.sv ====
/* 10G Ethernet interface top
   Transmit and receive MACs on XGMII plus the three-stage host path */
`default_nettype none

module xge_intf import xge_host_pkg::*; (
    input  logic         clk156_25,
    input  logic         arst_n,

    // MAC tx client
    input  logic         tx_underrun,
    input  logic [63:0]  tx_data,
    input  logic [7:0]   tx_data_valid,
    input  logic         tx_start,
    output logic         tx_ack,

    // MAC rx client
    output logic [63:0]  rx_data,
    output logic [7:0]   rx_data_valid,
    output logic         rx_good_frame,
    output logic         rx_bad_frame,

    // Host management
    input  host_opcode_t host_opcode,
    input  logic [9:0]   host_addr,
    input  logic [31:0]  host_wr_data,
    output logic [31:0]  host_rd_data,
    input  logic         host_req,
    output logic         host_rdy,

    // XGMII
    output logic [63:0]  xgmii_txd,
    output logic [7:0]   xgmii_txc,
    input  logic [63:0]  xgmii_rxd,
    input  logic [7:0]   xgmii_rxc
);

    // ----------------------------------------
    // Local wires
    logic        tx_enable;
    logic        rx_enable;
    logic        tx_frame_done;
    logic        dec_valid;
    host_op_t    dec_op;
    logic        dec_clear;
    logic [31:0] dec_wr_data;
    logic        exe_valid;
    host_op_t    exe_op;
    logic [31:0] exe_value;

    // ----------------------------------------
    // MAC
    mac_tx u_mac_tx (
        .clk156_25(clk156_25),              // I
        .arst_n(arst_n),                    // I
        .tx_enable(tx_enable),              // I from config
        .tx_start(tx_start),                // I
        .tx_underrun(tx_underrun),          // I
        .tx_data(tx_data),                  // I [63:0]
        .tx_data_valid(tx_data_valid),      // I [7:0]
        .tx_ack(tx_ack),                    // O
        .xgmii_txd(xgmii_txd),              // O [63:0]
        .xgmii_txc(xgmii_txc),              // O [7:0]
        .tx_frame_done(tx_frame_done)       // O to tx counter
    );

    mac_rx u_mac_rx (
        .clk156_25(clk156_25),              // I
        .arst_n(arst_n),                    // I
        .rx_enable(rx_enable),              // I from config
        .xgmii_rxd(xgmii_rxd),              // I [63:0]
        .xgmii_rxc(xgmii_rxc),              // I [7:0]
        .rx_data(rx_data),                  // O [63:0]
        .rx_data_valid(rx_data_valid),      // O [7:0]
        .rx_good_frame(rx_good_frame),      // O
        .rx_bad_frame(rx_bad_frame)         // O
    );

    // ----------------------------------------
    // Host path, request to ready in 3 cycles
    host_decode u_host_decode (
        .clk156_25(clk156_25),
        .arst_n(arst_n),
        .host_req(host_req),
        .host_opcode(host_opcode),
        .host_addr(host_addr),
        .host_wr_data(host_wr_data),
        .dec_valid(dec_valid),
        .dec_op(dec_op),
        .dec_clear(dec_clear),
        .dec_wr_data(dec_wr_data)
    );

    host_execute u_host_execute (
        .clk156_25(clk156_25),
        .arst_n(arst_n),
        .dec_valid(dec_valid),
        .dec_op(dec_op),
        .dec_clear(dec_clear),
        .dec_wr_data(dec_wr_data),
        .tx_frame_done(tx_frame_done),      // Frame events in
        .rx_good_frame(rx_good_frame),
        .rx_bad_frame(rx_bad_frame),
        .tx_enable(tx_enable),
        .rx_enable(rx_enable),
        .exe_valid(exe_valid),
        .exe_op(exe_op),
        .exe_value(exe_value)
    );

    host_result u_host_result (
        .clk156_25(clk156_25),
        .arst_n(arst_n),
        .exe_valid(exe_valid),
        .exe_op(exe_op),
        .exe_value(exe_value),
        .host_rdy(host_rdy),
        .host_rd_data(host_rd_data)
    );

endmodule

`default_nettype wire

// ==== test/xge_intf_sva.sv ====
/* Bound checks for the XGE interface
   Reset state, start word, frame pulses and host latency */
`default_nettype none

module xge_intf_sva import xge_mac_pkg::*; (
    input logic        clk156_25,
    input logic        arst_n,
    input tx_state_t   tx_state,
    input logic        tx_ack,
    input logic [63:0] xgmii_txd,
    input logic [7:0]  xgmii_txc,
    input logic [7:0]  rx_data_valid,
    input logic        rx_good_frame,
    input logic        rx_bad_frame,
    input logic        host_req,
    input logic        host_rdy
);

    timeunit 1ns;
    timeprecision 1ps;

    // First edge out of reset, all outputs quiet
    a_reset_quiet: assert property (@(posedge clk156_25)
        $rose(arst_n) |-> !tx_ack && !host_rdy && !rx_good_frame && !rx_bad_frame
                          && rx_data_valid == 8'h00 && xgmii_txc == 8'hFF
                          && xgmii_txd == {8{CH_IDLE}})
        else $error("Outputs not idle on the first edge after reset");

    a_ack_start: assert property (@(posedge clk156_25) disable iff (!arst_n)
        tx_ack |-> xgmii_txc == 8'h01
                   && xgmii_txd == {CH_SFD, {6{CH_PREAMBLE}}, CH_START})
        else $error("tx_ack without a start word in the same cycle");

    a_ack_single: assert property (@(posedge clk156_25) disable iff (!arst_n)
        tx_ack |=> !tx_ack)     // One-cycle strobe
        else $error("tx_ack held longer than one cycle");

    // Gap state forces an idle word onto the line
    a_gap_idle: assert property (@(posedge clk156_25) disable iff (!arst_n)
        tx_state == TX_GAP |=> xgmii_txc == 8'hFF && xgmii_txd == {8{CH_IDLE}})
        else $error("No idle word between frames");

    a_pulse_excl: assert property (@(posedge clk156_25) disable iff (!arst_n)
        !(rx_good_frame && rx_bad_frame))
        else $error("Good and bad frame pulses together");

    // Decode, execute, result
    a_host_latency: assert property (@(posedge clk156_25) disable iff (!arst_n)
        host_rdy == $past(host_req, 3))
        else $error("host_rdy not three cycles after host_req");

endmodule

`default_nettype wire

// ==== test/tb_xge_intf.sv ====
/* Testbench for the XGE interface
   XGMII loopback, random frames, underrun, host register access */
`include "xge_defines.svh"

`default_nettype none

module tb_xge_intf import xge_host_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic         clk156_25;
    logic         arst_n;
    logic         tx_underrun;
    logic [63:0]  tx_data;
    logic [7:0]   tx_data_valid;
    logic         tx_start;
    logic         tx_ack;
    logic [63:0]  rx_data;
    logic [7:0]   rx_data_valid;
    logic         rx_good_frame;
    logic         rx_bad_frame;
    host_opcode_t host_opcode;
    logic [9:0]   host_addr;
    logic [31:0]  host_wr_data;
    logic [31:0]  host_rd_data;
    logic         host_req;
    logic         host_rdy;
    logic [63:0]  xgmii_txd;
    logic [7:0]   xgmii_txc;

    integer       seed = 55;
    int           errors = 0;
    int           good_seen = 0;    // Rx pulses observed
    int           bad_seen = 0;
    int           good_sent = 0;    // Rx pulses due
    int           bad_sent = 0;
    logic [31:0]  cnt_tx = 0;       // Host counter model
    logic [31:0]  cnt_good = 0;
    logic [31:0]  cnt_bad = 0;
    logic [72:0]  exp_q[$];         // {last, mask, data} per word

    // XGMII looped straight back
    xge_intf u_xge_intf (
        .clk156_25(clk156_25),
        .arst_n(arst_n),
        .tx_underrun(tx_underrun),
        .tx_data(tx_data),
        .tx_data_valid(tx_data_valid),
        .tx_start(tx_start),
        .tx_ack(tx_ack),
        .rx_data(rx_data),
        .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame),
        .rx_bad_frame(rx_bad_frame),
        .host_opcode(host_opcode),
        .host_addr(host_addr),
        .host_wr_data(host_wr_data),
        .host_rd_data(host_rd_data),
        .host_req(host_req),
        .host_rdy(host_rdy),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc),
        .xgmii_rxd(xgmii_txd),
        .xgmii_rxc(xgmii_txc)
    );

    bind xge_intf xge_intf_sva u_xge_intf_sva (
        .clk156_25(clk156_25),
        .arst_n(arst_n),
        .tx_state(u_mac_tx.state),
        .tx_ack(tx_ack),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc),
        .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame),
        .rx_bad_frame(rx_bad_frame),
        .host_req(host_req),
        .host_rdy(host_rdy)
    );

    initial begin
        clk156_25 = 1'b0;
        forever #20 clk156_25 = ~clk156_25;    // 25 MHz sim clock
    end

    // ----------------------------------------
    // Helpers
    function automatic logic [63:0] lane_bits(input logic [7:0] mask);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < 8; i++) begin
            bits[8*i +: 8] = {8{mask[i]}};
        end
        return bits;
    endfunction

    function automatic void check_value(input string name, input logic [63:0] exp,
                                        input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endfunction

    task automatic next_drive_slot();
        @(posedge clk156_25);
        #2;                         // Inputs move just after the edge
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(negedge clk156_25);
            n++;
        end while (!host_rdy && n < 20);
        if (!host_rdy) begin
            $display("Timeout waiting for host_rdy");
            errors++;
        end
    endtask

    task automatic wait_rx();
        int n;
        n = 0;
        while ((good_seen < good_sent || bad_seen < bad_sent) && n < 60) begin
            @(negedge clk156_25);
            n++;
        end
        if (good_seen < good_sent || bad_seen < bad_sent) begin
            $display("Timeout waiting for receive frame pulses");
            errors++;
        end
    endtask

    // One host request, read data compared on host_rdy
    task automatic access_expect(input string name, input host_opcode_t op,
                                 input logic [9:0] addr, input logic [31:0] wdata,
                                 input logic [31:0] exp);
        next_drive_slot();
        host_req     = 1'b1;
        host_opcode  = op;
        host_addr    = addr;
        host_wr_data = wdata;
        next_drive_slot();
        host_req = 1'b0;
        wait_ready();
        check_value(name, 64'(exp), 64'(host_rd_data));
    endtask

    // Start held until ack, then one word per cycle
    task automatic send_frame(input int words, input logic [7:0] last_mask,
                              input int underrun_at, output bit acked);
        int          n;
        logic [63:0] d;
        logic [7:0]  m;
        n     = 0;
        acked = 1'b0;
        next_drive_slot();
        tx_start = 1'b1;
        while (!acked && n < 20) begin
            @(negedge clk156_25);
            acked = tx_ack;
            n++;
        end
        next_drive_slot();
        tx_start = 1'b0;
        if (acked) begin
            for (int i = 0; i < words; i++) begin
                d = {$random(seed), $random(seed)};
                m = (i == words - 1) ? last_mask : 8'hFF;
                tx_data       = d;
                tx_data_valid = m;
                tx_underrun   = (i == underrun_at);
                if (!tx_underrun) begin
                    exp_q.push_back({(m != 8'hFF), m, d});
                end
                next_drive_slot();
                if (i == underrun_at) begin
                    break;          // Poisoned word ends the frame
                end
            end
            tx_data_valid = 8'h00;
            tx_underrun   = 1'b0;
            if (underrun_at < 0) begin
                good_sent++;
                cnt_good = cnt_good + 32'd1;
                cnt_tx   = cnt_tx + 32'd1;
            end else begin
                bad_sent++;
                cnt_bad = cnt_bad + 32'd1;
            end
        end
    endtask

    // ----------------------------------------
    // Rx monitor, sampled mid-cycle
    always @(negedge clk156_25) begin
        logic [72:0] e;
        if (arst_n && (rx_data_valid != 8'h00 || rx_good_frame || rx_bad_frame)) begin
            if (rx_bad_frame) begin
                check_value("rx_bad_mask", 64'd0, 64'(rx_data_valid));
                bad_seen++;
            end else if (exp_q.size() == 0) begin
                $display("Unexpected receive word %h with mask %h", rx_data, rx_data_valid);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("rx_mask", 64'(e[71:64]), 64'(rx_data_valid));
                check_value("rx_data", e[63:0] & lane_bits(e[71:64]),
                            rx_data & lane_bits(e[71:64]));
                check_value("rx_good_frame", 64'(e[72]), 64'(rx_good_frame));
                if (rx_good_frame) begin
                    good_seen++;
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    initial begin
        bit           acked;
        int           words;
        int           k;
        logic [7:0]   mask;
        host_opcode_t ops [6];
        logic [9:0]   addrs [6];
        logic [31:0]  wdata [6];
        logic [31:0]  exps [6];
        arst_n        = 1'b0;
        tx_underrun   = 1'b0;
        tx_data       = '0;
        tx_data_valid = 8'h00;
        tx_start      = 1'b0;
        host_req      = 1'b0;
        host_opcode   = HOST_NOP;
        host_addr     = '0;
        host_wr_data  = '0;
        repeat (2) @(posedge clk156_25);
        #2;
        arst_n = 1'b1;

        access_expect("cfg_after_reset", HOST_READ, `XGE_ADDR_CFG, 32'd0, 32'd3);

        // Random good frames, first one ends on a zero mask
        for (int f = 0; f < 8; f++) begin
            words = 1 + int'($unsigned($random(seed)) % 6);
            k     = (f == 0) ? 0 : int'($unsigned($random(seed)) % 8);
            mask  = 8'h00;
            for (int j = 0; j < k; j++) begin
                mask[j] = 1'b1;
            end
            send_frame(words, mask, -1, acked);
            if (!acked) begin
                $display("No tx_ack for frame %0d", f);
                errors++;
            end
        end
        wait_rx();

        send_frame(4, 8'h0F, 2, acked);     // Underrun on the third word
        if (!acked) begin
            $display("No tx_ack for the underrun frame");
            errors++;
        end
        wait_rx();

        access_expect("tx_count", HOST_READ, `XGE_ADDR_TX_CNT, 32'd0, cnt_tx);
        access_expect("rx_good_count", HOST_READ, `XGE_ADDR_RX_GOOD_CNT, 32'd0, cnt_good);
        access_expect("rx_bad_count", HOST_READ, `XGE_ADDR_RX_BAD_CNT, 32'd0, cnt_bad);
        access_expect("rx_good_read_clear", HOST_READ_CLEAR, `XGE_ADDR_RX_GOOD_CNT,
                      32'd0, cnt_good);
        cnt_good = 32'd0;
        access_expect("rx_good_after_clear", HOST_READ, `XGE_ADDR_RX_GOOD_CNT,
                      32'd0, cnt_good);

        // Both enables off, no ack expected
        access_expect("cfg_write_zero", HOST_WRITE, `XGE_ADDR_CFG, 32'd0, 32'd0);
        access_expect("cfg_disabled", HOST_READ, `XGE_ADDR_CFG, 32'd0, 32'd0);
        send_frame(2, 8'h07, -1, acked);
        if (acked) begin
            $display("tx_ack seen while transmit was disabled");
            errors++;
        end
        access_expect("cfg_write_three", HOST_WRITE, `XGE_ADDR_CFG, 32'd3, 32'd0);
        send_frame(2, 8'h3F, -1, acked);
        if (!acked) begin
            $display("No tx_ack after transmit was enabled again");
            errors++;
        end
        wait_rx();

        // Back-to-back requests, one per cycle
        ops   = '{HOST_WRITE, HOST_READ, HOST_READ, HOST_READ, HOST_NOP, HOST_READ};
        addrs = '{`XGE_ADDR_TX_CNT, `XGE_ADDR_TX_CNT, 10'h3F0, `XGE_ADDR_CFG,
                  `XGE_ADDR_CFG, `XGE_ADDR_RX_BAD_CNT};
        wdata = '{32'hDEAD_BEEC, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0};
        exps  = '{32'd0, cnt_tx, 32'd0, 32'd3, 32'd0, cnt_bad};  // Counter write ignored
        fork
            begin
                for (int r = 0; r < 6; r++) begin
                    next_drive_slot();
                    host_req     = 1'b1;
                    host_opcode  = ops[r];
                    host_addr    = addrs[r];
                    host_wr_data = wdata[r];
                end
                next_drive_slot();
                host_req = 1'b0;
            end
            begin
                for (int r = 0; r < 6; r++) begin
                    wait_ready();
                    check_value($sformatf("burst_%0d", r), 64'(exps[r]), 64'(host_rd_data));
                end
            end
        join

        if (exp_q.size() != 0) begin
            $display("%0d expected receive words never arrived", exp_q.size());
            errors++;
        end
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
rtl/xge_mac_pkg.sv
rtl/xge_host_pkg.sv
rtl/mac_tx.sv
rtl/mac_rx.sv
rtl/host_decode.sv
rtl/host_execute.sv
rtl/host_result.sv
rtl/xge_intf.sv
test/xge_intf_sva.sv
test/tb_xge_intf.sv

// ==== Makefile ====
# Verilator flow for the XGE interface testbench
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f compile.f --top-module tb_xge_intf
	./obj_dir/Vtb_xge_intf 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "RESULT: FAIL"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f compile.f --top-module xge_intf

clean:
	rm -rf obj_dir sim.log
